/* design/demodPkg.sv */
package demodPkg;

    // sample, video and average words
    typedef logic signed [17:0] sampleT;
    // full 18x18 multiplier result
    typedef logic signed [35:0] productT;
    // alpha and threshold register values
    typedef logic [15:0] coefT;
    typedef logic [3:0] dacSelT;

    typedef logic [11:0] apbAddrT;
    typedef logic [31:0] apbDataT;

    typedef enum logic [1:0] {
        apbIdle,
        apbSetup,
        apbAccess
    } apbStateT;

    // register map
    localparam apbAddrT addrControl   = 12'h000;
    localparam apbAddrT addrAlpha     = 12'h004;
    localparam apbAddrT addrThreshold = 12'h008;
    localparam apbAddrT addrStatus    = 12'h00C;

    // unlisted DAC select codes fall back to dacI
    localparam dacSelT dacI          = 4'd0;
    localparam dacSelT dacQ          = 4'd1;
    localparam dacSelT dacFreq       = 4'd2;
    localparam dacSelT dacAvgFreq    = 4'd3;
    localparam dacSelT dacAvgAbsFreq = 4'd4;

    // average |freq| above this forces the offset flag
    localparam sampleT absBypassLimit = 18'h10000;

    localparam apbDataT controlResetValue = 32'd0;

endpackage

/* design/demodRegs.sv */
`timescale 1ns/1ps

module demodRegs (
    input  logic              clk,
    input  logic              arstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  demodPkg::apbAddrT paddr,
    input  demodPkg::apbDataT pwdata,
    input  logic              highFreqOffset,
    input  logic              carrierLock,
    output demodPkg::apbDataT prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              iqSwap,
    output demodPkg::coefT    falseLockAlpha,
    output demodPkg::coefT    falseLockThreshold,
    output demodPkg::dacSelT  dac0Select,
    output demodPkg::dacSelT  dac1Select
);
    import demodPkg::*;

    apbStateT state;
    logic     accessPhase;
    logic     addrValid;
    apbDataT  controlReg;
    coefT     alphaReg;
    coefT     thresholdReg;

    // access phase only counts after a seen setup
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= apbIdle;
        end else begin
            case (state)
                apbIdle:   state <= (psel && !penable) ? apbSetup : apbIdle;
                apbSetup:  begin
                    if (psel && penable) begin
                        state <= apbAccess;
                    end else if (!psel) begin
                        state <= apbIdle;
                    end
                end
                default:   state <= (psel && !penable) ? apbSetup : apbIdle;
            endcase
        end
    end

    assign accessPhase = (state == apbSetup) && psel && penable;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            controlReg   <= controlResetValue;
            alphaReg     <= '0;
            thresholdReg <= '0;
        end else if (accessPhase && pwrite) begin
            case (paddr)
                // only the defined control fields are kept
                addrControl:   controlReg <= {20'd0, pwdata[11:4], 3'd0, pwdata[0]};
                addrAlpha:     alphaReg <= pwdata[15:0];
                addrThreshold: thresholdReg <= pwdata[15:0];
                default:       ;
            endcase
        end
    end

    // read mux and address decode
    always_comb begin
        addrValid = 1'b1;
        prdata    = '0;
        case (paddr)
            addrControl:   prdata = controlReg;
            addrAlpha:     prdata = {16'd0, alphaReg};
            addrThreshold: prdata = {16'd0, thresholdReg};
            addrStatus:    prdata = {30'd0, carrierLock, highFreqOffset};
            default:       addrValid = 1'b0;
        endcase
    end

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = accessPhase && !addrValid;

    assign iqSwap             = controlReg[0];
    assign dac0Select         = controlReg[7:4];
    assign dac1Select         = controlReg[11:8];
    assign falseLockAlpha     = alphaReg;
    assign falseLockThreshold = thresholdReg;

endmodule

/* design/fmDiscriminator.sv */
`timescale 1ns/1ps

module fmDiscriminator (
    input  logic             clk,
    input  logic             arstN,
    input  logic             sampleEn,
    input  demodPkg::sampleT iIn,
    input  demodPkg::sampleT qIn,
    input  logic             iqSwap,
    output demodPkg::sampleT iSample,
    output demodPkg::sampleT qSample,
    output logic             swapEn,
    output demodPkg::sampleT fmVideo,
    output logic             fmEn
);
    import demodPkg::*;

    sampleT  iPrev;
    sampleT  qPrev;
    productT crossA;
    productT crossB;
    productT crossDiff;

    // input stage with optional swap
    always_ff @(posedge clk) begin
        if (sampleEn) begin
            iSample <= iqSwap ? qIn : iIn;
            qSample <= iqSwap ? iIn : qIn;
        end
    end

    // previous I times current Q minus previous Q times current I
    assign crossA    = iPrev * qSample;
    assign crossB    = qPrev * iSample;
    assign crossDiff = crossA - crossB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            swapEn <= 1'b0;
            fmEn   <= 1'b0;
            iPrev  <= '0;
            qPrev  <= '0;
        end else begin
            swapEn <= sampleEn;
            fmEn   <= swapEn;
            if (swapEn) begin
                iPrev <= iSample;
                qPrev <= qSample;
            end
        end
    end

    // truncated video word
    always_ff @(posedge clk) begin
        if (swapEn) begin
            fmVideo <= crossDiff[34:17];
        end
    end

endmodule

/* design/falseLockDetector.sv */
`timescale 1ns/1ps

module falseLockDetector (
    input  logic             clk,
    input  logic             arstN,
    input  logic             fmEn,
    input  demodPkg::sampleT fmVideo,
    input  demodPkg::coefT   falseLockAlpha,
    input  demodPkg::coefT   falseLockThreshold,
    input  logic             carrierLock,
    output demodPkg::sampleT averageFreq,
    output demodPkg::sampleT averageAbsFreq,
    output logic             avgEn,
    output logic             highFreqOffset
);
    import demodPkg::*;

    sampleT  alpha;
    sampleT  oneMinusAlpha;
    sampleT  freqSample;
    sampleT  absFreqSample;
    sampleT  absAverageFreq;
    productT freqAlpha;
    productT freqHold;
    productT absAlpha;
    productT absHold;
    productT freqSum;
    productT absSum;
    logic    sampleValid;
    logic    productValid;

    // 1.0 sits at bit 17
    assign alpha         = {falseLockAlpha, 2'b00};
    assign oneMinusAlpha = 18'h20000 - alpha;

    assign freqSum        = freqAlpha + freqHold;
    assign absSum         = absAlpha + absHold;
    assign absAverageFreq = averageFreq[17] ? -averageFreq : averageFreq;

    always_ff @(posedge clk) begin
        if (fmEn) begin
            freqSample    <= fmVideo;
            absFreqSample <= fmVideo[17] ? -fmVideo : fmVideo;
        end
        // weighted terms one cycle after the sample
        freqAlpha <= freqSample * alpha;
        freqHold  <= averageFreq * oneMinusAlpha;
        absAlpha  <= absFreqSample * alpha;
        absHold   <= averageAbsFreq * oneMinusAlpha;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sampleValid    <= 1'b0;
            productValid   <= 1'b0;
            avgEn          <= 1'b0;
            averageFreq    <= '0;
            averageAbsFreq <= '0;
            highFreqOffset <= 1'b0;
        end else begin
            sampleValid  <= fmEn;
            productValid <= sampleValid;
            avgEn        <= productValid;
            if (productValid) begin
                averageFreq    <= freqSum[34:17];
                averageAbsFreq <= absSum[34:17];
            end
            // large average offset wins over carrier lock
            if (avgEn) begin
                if ($unsigned(averageAbsFreq) > $unsigned(absBypassLimit)) begin
                    highFreqOffset <= 1'b1;
                end else if ($unsigned(absAverageFreq) > 18'(falseLockThreshold)) begin
                    highFreqOffset <= !carrierLock;
                end else begin
                    highFreqOffset <= 1'b0;
                end
            end
        end
    end

endmodule

/* design/dacMux.sv */
`timescale 1ns/1ps

module dacMux (
    input  logic             clk,
    input  logic             arstN,
    input  demodPkg::dacSelT dac0Select,
    input  demodPkg::dacSelT dac1Select,
    input  demodPkg::sampleT iSample,
    input  demodPkg::sampleT qSample,
    input  logic             swapEn,
    input  demodPkg::sampleT fmVideo,
    input  logic             fmEn,
    input  demodPkg::sampleT averageFreq,
    input  demodPkg::sampleT averageAbsFreq,
    input  logic             avgEn,
    output demodPkg::sampleT dac0Data,
    output demodPkg::sampleT dac1Data,
    output logic             dac0Sync,
    output logic             dac1Sync
);
    import demodPkg::*;

    logic [18:0] pick0;
    logic [18:0] pick1;

    // strobe in the top bit, data below
    function automatic logic [18:0] pickSource(input dacSelT sel);
        case (sel)
            dacQ:          return {swapEn, qSample};
            dacFreq:       return {fmEn, fmVideo};
            dacAvgFreq:    return {avgEn, averageFreq};
            dacAvgAbsFreq: return {avgEn, averageAbsFreq};
            default:       return {swapEn, iSample};
        endcase
    endfunction

    assign pick0 = pickSource(dac0Select);
    assign pick1 = pickSource(dac1Select);

    always_ff @(posedge clk) begin
        dac0Data <= pick0[17:0];
        dac1Data <= pick1[17:0];
    end

    // sync is the source strobe one cycle late
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dac0Sync <= 1'b0;
            dac1Sync <= 1'b0;
        end else begin
            dac0Sync <= pick0[18];
            dac1Sync <= pick1[18];
        end
    end

endmodule

/* design/demodTop.sv */
`timescale 1ns/1ps

module demodTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  demodPkg::apbAddrT paddr,
    input  demodPkg::apbDataT pwdata,
    output demodPkg::apbDataT prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              sampleEn,
    input  demodPkg::sampleT  iIn,
    input  demodPkg::sampleT  qIn,
    input  logic              carrierLock,
    output demodPkg::sampleT  dac0Data,
    output logic              dac0Sync,
    output demodPkg::sampleT  dac1Data,
    output logic              dac1Sync
);
    import demodPkg::*;

    // configuration
    logic   iqSwap;
    coefT   falseLockAlpha;
    coefT   falseLockThreshold;
    dacSelT dac0Select;
    dacSelT dac1Select;

    // datapath
    sampleT iSample;
    sampleT qSample;
    logic   swapEn;
    sampleT fmVideo;
    logic   fmEn;
    sampleT averageFreq;
    sampleT averageAbsFreq;
    logic   avgEn;
    logic   highFreqOffset;

    demodRegs u_regs (
        .clk, .arstN, .psel, .penable, .pwrite, .paddr, .pwdata,
        .highFreqOffset, .carrierLock, .prdata, .pready, .pslverr,
        .iqSwap, .falseLockAlpha, .falseLockThreshold, .dac0Select, .dac1Select
    );

    fmDiscriminator u_fmDisc (
        .clk, .arstN, .sampleEn, .iIn, .qIn, .iqSwap,
        .iSample, .qSample, .swapEn, .fmVideo, .fmEn
    );

    falseLockDetector u_falseLock (
        .clk, .arstN, .fmEn, .fmVideo, .falseLockAlpha, .falseLockThreshold,
        .carrierLock, .averageFreq, .averageAbsFreq, .avgEn, .highFreqOffset
    );

    dacMux u_dacMux (
        .clk, .arstN, .dac0Select, .dac1Select, .iSample, .qSample, .swapEn,
        .fmVideo, .fmEn, .averageFreq, .averageAbsFreq, .avgEn,
        .dac0Data, .dac1Data, .dac0Sync, .dac1Sync
    );

endmodule

/* verif/demodChecks.sv */
`timescale 1ns/1ps

module demodChecks (
    input  logic              clk,
    input  logic              arstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  demodPkg::apbAddrT paddr,
    input  demodPkg::apbDataT pwdata,
    input  demodPkg::apbDataT prdata,
    input  logic              pready,
    input  logic              pslverr,
    input  logic              sampleEn,
    input  demodPkg::sampleT  iIn,
    input  demodPkg::sampleT  qIn,
    input  logic              carrierLock,
    input  demodPkg::sampleT  dac0Data,
    input  logic              dac0Sync,
    input  demodPkg::sampleT  dac1Data,
    input  logic              dac1Sync,
    output int                errCount,
    output int                checkCount
);
    import demodPkg::*;

    // expected values indexed by edges since the strobe
    localparam int depth = 7;

    logic   swapModel;
    dacSelT sel0Model;
    dacSelT sel1Model;
    coefT   alphaModel;
    coefT   thrModel;
    logic   flagModel;
    longint prevI;
    longint prevQ;
    longint avgF;
    longint avgA;
    logic   lineValid [depth];
    longint lineI     [depth];
    longint lineQ     [depth];
    longint lineVid   [depth];
    longint lineAvgF  [depth];
    longint lineAvgA  [depth];

    // two's complement wrap to 18 bits
    function automatic longint wrap18(input longint v);
        longint m;
        m = ((v % 262144) + 262144) % 262144;
        return (m >= 131072) ? m - 262144 : m;
    endfunction

    function automatic longint unsigned18(input longint v);
        return (v < 0) ? v + 262144 : v;
    endfunction

    function automatic longint abs18(input longint v);
        return (v < 0) ? wrap18(-v) : v;
    endfunction

    // x * alpha + avg * (1 - alpha) with alpha the register shifted up two bits
    function automatic longint averageStep(input longint x, input longint avg);
        longint a;
        longint oneMinus;
        a = wrap18(longint'(alphaModel) * 4);
        oneMinus = wrap18(131072 - a);
        return wrap18((x * a + avg * oneMinus) >>> 17);
    endfunction

    function automatic logic flagRule(input longint freq, input longint absFreq);
        if (unsigned18(absFreq) > longint'(absBypassLimit)) begin
            return 1'b1;
        end else if (unsigned18(abs18(freq)) > longint'(thrModel)) begin
            return !carrierLock;
        end
        return 1'b0;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        assert (got == expected) else begin
            errCount++;
            $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    // one strobe through swap, cross product and both averages
    task automatic modelSample(input longint i, input longint q);
        longint si;
        longint sq;
        longint vid;
        si = swapModel ? q : i;
        sq = swapModel ? i : q;
        vid = wrap18((prevI * sq - prevQ * si) >>> 17);
        avgF = averageStep(vid, avgF);
        avgA = averageStep(abs18(vid), avgA);
        prevI = si;
        prevQ = sq;
        lineValid[0] = 1'b1;
        lineI[0] = si;
        lineQ[0] = sq;
        lineVid[0] = vid;
        lineAvgF[0] = avgF;
        lineAvgA[0] = avgA;
    endtask

    task automatic checkBus();
        logic    known;
        apbDataT expected;
        known = (paddr == addrControl) || (paddr == addrAlpha) ||
                (paddr == addrThreshold) || (paddr == addrStatus);
        if (!(psel && penable)) begin
            compareValue("pslverr", 32'(pslverr), 32'd0);
        end else begin
            compareValue("pready", 32'(pready), 32'd1);
            compareValue("pslverr", 32'(pslverr), 32'(!known));
            if (!pwrite && known) begin
                case (paddr)
                    addrControl:   expected = {20'd0, sel1Model, sel0Model, 3'd0, swapModel};
                    addrAlpha:     expected = {16'd0, alphaModel};
                    addrThreshold: expected = {16'd0, thrModel};
                    default:       expected = {30'd0, carrierLock, flagModel};
                endcase
                compareValue("prdata", prdata, expected);
            end else if (pwrite) begin
                case (paddr)
                    addrControl: begin
                        swapModel = pwdata[0];
                        sel0Model = pwdata[7:4];
                        sel1Model = pwdata[11:8];
                    end
                    addrAlpha:     alphaModel = pwdata[15:0];
                    addrThreshold: thrModel = pwdata[15:0];
                    default:       ;
                endcase
            end
        end
    endtask

    // I and Q show two edges after the strobe, video three, averages six
    task automatic checkChannel(input string dataName, input string syncName,
                                input dacSelT sel, input logic sync, input sampleT data);
        int     age;
        longint expected;
        age = 2;
        expected = lineI[2];
        case (sel)
            dacQ:    expected = lineQ[2];
            dacFreq: begin
                age = 3;
                expected = lineVid[3];
            end
            dacAvgFreq: begin
                age = 6;
                expected = lineAvgF[6];
            end
            dacAvgAbsFreq: begin
                age = 6;
                expected = lineAvgA[6];
            end
            default: ;
        endcase
        compareValue(syncName, 32'(sync), 32'(lineValid[age]));
        if (lineValid[age]) begin
            compareValue(dataName, {14'd0, data}, 32'(unsigned18(expected)));
        end
    endtask

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            errCount = 0;
            checkCount = 0;
            swapModel = 1'b0;
            sel0Model = dacI;
            sel1Model = dacI;
            alphaModel = '0;
            thrModel = '0;
            flagModel = 1'b0;
            prevI = 0;
            prevQ = 0;
            avgF = 0;
            avgA = 0;
            for (int d = 0; d < depth; d++) begin
                lineValid[d] = 1'b0;
            end
        end else begin
            for (int d = depth - 1; d > 0; d--) begin
                lineValid[d] = lineValid[d - 1];
                lineI[d] = lineI[d - 1];
                lineQ[d] = lineQ[d - 1];
                lineVid[d] = lineVid[d - 1];
                lineAvgF[d] = lineAvgF[d - 1];
                lineAvgA[d] = lineAvgA[d - 1];
            end
            lineValid[0] = 1'b0;
            if (sampleEn) begin
                modelSample(iIn, qIn);
            end
            checkBus();
            checkChannel("dac0Data", "dac0Sync", sel0Model, dac0Sync, dac0Data);
            checkChannel("dac1Data", "dac1Sync", sel1Model, dac1Sync, dac1Data);
            // flag register follows one edge after the averages
            if (lineValid[5]) begin
                flagModel = flagRule(lineAvgF[5], lineAvgA[5]);
            end
        end
    end

endmodule

/* verif/demodTb.sv */
`timescale 1ns/1ps

module demodTb;
    import demodPkg::*;

    localparam int clkPeriod = 20;
    localparam int resetCycles = 8;
    localparam int sampleGap = 3;
    localparam int drainCycles = 10;
    // totals over all tests
    localparam int apbOps = 28;
    localparam int sampleCount = 68;
    localparam int drainCount = 9;
    localparam int watchdogCycles = resetCycles + apbOps * 3 + sampleCount * (sampleGap + 1)
                                    + drainCount * drainCycles + 50;

    logic        clk;
    logic        arstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apbAddrT     paddr;
    apbDataT     pwdata;
    apbDataT     prdata;
    logic        pready;
    logic        pslverr;
    logic        sampleEn;
    sampleT      iIn;
    sampleT      qIn;
    logic        carrierLock;
    sampleT      dac0Data;
    logic        dac0Sync;
    sampleT      dac1Data;
    logic        dac1Sync;
    int          errCount;
    int          checkCount;
    int          testCount;
    int          errMark;
    logic [31:0] lcgState;

    demodTop u_dut (.*);

    demodChecks u_checks (.*);

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic apbTransfer(input logic write, input apbAddrT addr, input apbDataT data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(input apbAddrT addr, input apbDataT data);
        apbTransfer(1'b1, addr, data);
    endtask

    task automatic apbRead(input apbAddrT addr);
        apbTransfer(1'b0, addr, '0);
    endtask

    task automatic sendSample(input sampleT i, input sampleT q);
        @(posedge clk);
        sampleEn <= 1'b1;
        iIn      <= i;
        qIn      <= q;
        @(posedge clk);
        sampleEn <= 1'b0;
        repeat (sampleGap - 1) @(posedge clk);
    endtask

    task automatic sendRandom(input int count);
        sampleT i;
        sampleT q;
        repeat (count) begin
            lcgState = nextRandom(lcgState);
            i = lcgState[31:14];
            lcgState = nextRandom(lcgState);
            q = lcgState[31:14];
            sendSample(i, q);
        end
    endtask

    // quarter turns that rotate steadily or go back and forth
    task automatic sendRotation(input sampleT amp, input int count, input logic alternate);
        int step;
        for (int n = 0; n < count; n++) begin
            step = alternate ? n % 2 : n % 4;
            case (step)
                0:       sendSample(amp, 18'sd0);
                1:       sendSample(18'sd0, amp);
                2:       sendSample(-amp, 18'sd0);
                default: sendSample(18'sd0, -amp);
            endcase
        end
    endtask

    task automatic drain();
        repeat (drainCycles) @(posedge clk);
    endtask

    task automatic reportTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errCount - errMark);
        errMark = errCount;
    endtask

    initial begin
        arstN = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        sampleEn = 1'b0;
        iIn = '0;
        qIn = '0;
        carrierLock = 1'b0;
        lcgState = 32'd21;
        testCount = 0;
        errMark = 0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;

        apbRead(addrControl);
        apbRead(addrAlpha);
        apbRead(addrThreshold);
        apbRead(addrStatus);
        apbWrite(addrControl, 32'hFFFF_FFFF);
        apbWrite(addrAlpha, 32'h1234_ABCD);
        apbWrite(addrThreshold, 32'hFFFF_5A5A);
        apbWrite(addrStatus, 32'h0000_0003);
        apbRead(addrControl);
        apbRead(addrAlpha);
        apbRead(addrThreshold);
        apbRead(addrStatus);
        apbRead(12'h010);
        apbWrite(12'h00E, 32'h0000_0001);
        apbWrite(addrControl, 32'h0);
        reportTest("register access");

        // channel 0 on I, channel 1 on Q, then swapped
        apbWrite(addrControl, 32'h100);
        sendRandom(8);
        drain();
        apbWrite(addrControl, 32'h101);
        sendRandom(8);
        drain();
        reportTest("I/Q pass and swap");

        apbWrite(addrControl, 32'h120);
        sendRandom(8);
        drain();
        apbWrite(addrControl, 32'h121);
        sendRandom(8);
        drain();
        reportTest("FM discriminator");

        apbWrite(addrAlpha, 32'hFFFF);
        apbWrite(addrControl, 32'h430);
        sendRotation(18'sh04000, 12, 1'b0);
        drain();
        reportTest("averages");

        // alpha near one so the averages track the video
        apbWrite(addrAlpha, 32'h7FFF);
        apbWrite(addrThreshold, 32'h10);
        sendRotation(18'sh04000, 8, 1'b0);
        drain();
        apbRead(addrStatus);
        @(posedge clk);
        carrierLock <= 1'b1;
        sendRotation(18'sh04000, 4, 1'b0);
        drain();
        apbRead(addrStatus);
        apbWrite(addrThreshold, 32'h7FFF);
        sendRotation(18'sh04000, 4, 1'b0);
        drain();
        apbRead(addrStatus);
        sendRotation(18'sd120000, 8, 1'b1);
        drain();
        apbRead(addrStatus);
        reportTest("offset flag");

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("timeout: run did not finish within %0d cycles", watchdogCycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* all.f */
design/demodPkg.sv
design/demodRegs.sv
design/fmDiscriminator.sv
design/falseLockDetector.sv
design/dacMux.sv
design/demodTop.sv
verif/demodChecks.sv
verif/demodTb.sv

/* Makefile */
TOP = demodTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@grep -qx "Test OK" sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
